// File: rv_core.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
# The result is decided by the pass message in sim.log.

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o sim_tb_rv_core \
    && ./obj_dir/sim_tb_rv_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// File: tb_rv_core.sv
// ==================================================
// Random-stimulus testbench for rv_core against an in-order model
// Registers are drawn from x0..x7 so hazards are frequent
// Retire latency is checked as exactly three edges after the strobe
// ==================================================
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    // About 400 strobes, gaps in one test only, plus reset and drains
    localparam int MAX_CYCLES = 1000;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   data;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;
        logic                  illegal;
        logic [31:0]           cycle;
    } retire_t;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_instr_valid;
    logic [`RV_XLEN-1:0]   i_instr;
    logic                  o_wb_valid;
    logic                  o_wb_we;
    logic                  o_wb_illegal;
    logic [`RV_REG_AW-1:0] o_wb_rd;
    logic [`RV_XLEN-1:0]   o_wb_data;

    logic [31:0]         rng_state = 32'h7ba7_3f08;
    logic [`RV_XLEN-1:0] model_regs [0:`RV_NUM_REGS-1];
    retire_t             exp_q [$];
    logic [31:0]         neg_count = '0;
    int                  cycle_count = 0;
    int                  err_count = 0;
    int                  tests_passed = 0;
    int                  tests_failed = 0;

    rv_core UUT (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .o_wb_we       (o_wb_we),
        .o_wb_illegal  (o_wb_illegal),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

    initial begin
        forever #50 i_clk = ~i_clk;
    end

    // ==================================================
    // Random numbers and instruction encoding
    // ==================================================
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [`RV_REG_AW-1:0] rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return {2'b00, r[18:16]};
    endfunction

    // Never x0
    function automatic logic [`RV_REG_AW-1:0] rand_dst();
        logic [31:0] r;
        r = lcg_next();
        return (r[18:16] == 3'd0) ? 5'd1 : {2'b00, r[18:16]};
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] rand_op(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        r   = lcg_next();
        f3  = r[14:12];
        alt = r[30] && ((f3 == 3'd0) || (f3 == 3'd5));
        return encode_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    endfunction

    function automatic logic [31:0] rand_imm(input logic [4:0] rd, input logic [4:0] rs1);
        logic [31:0] r;
        logic [11:0] imm;
        r   = lcg_next();
        imm = r[31:20];
        if (r[14:12] == 3'd1) begin
            imm = {7'h00, r[24:20]};
        end else if (r[14:12] == 3'd5) begin
            imm = {(r[30] ? 7'h20 : 7'h00), r[24:20]};
        end
        return encode_i(imm, rs1, r[14:12], rd);
    endfunction

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Predict the retire record, then strobe the instruction and idle for gap cycles
    task automatic issue(input logic [`RV_XLEN-1:0] instr, input int gap);
        logic [6:0]          opc;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic                legal;
        logic                alt;
        logic [`RV_XLEN-1:0] op_b;
        retire_t             rec;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        legal = 1'b0;
        alt   = 1'b0;
        op_b  = '0;
        if (opc == OPC_OP) begin
            legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            alt   = instr[30];
            op_b  = model_regs[instr[24:20]];
        end else if (opc == OPC_OP_IMM) begin
            legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
            alt   = (f3 == 3'd5) && instr[30];
            op_b  = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
        end
        rec.data    = alu_model(f3, alt, model_regs[instr[19:15]], op_b);
        rec.rd      = instr[11:7];
        rec.illegal = !legal;
        rec.we      = legal && (instr[11:7] != 5'd0);
        @(posedge i_clk);
        // Sampled on the next edge, visible at the negedge after three more edges
        rec.cycle = neg_count + 32'd4;
        if (rec.we) begin
            model_regs[rec.rd] = rec.data;
        end
        exp_q.push_back(rec);
        i_instr_valid <= 1'b1;
        i_instr       <= instr;
        repeat (gap) begin
            @(posedge i_clk);
            i_instr_valid <= 1'b0;
        end
    endtask

    // ==================================================
    // Compare tasks and retire monitor
    // ==================================================
    task automatic check_data(input string name, input logic [`RV_XLEN-1:0] expected,
                              input logic [`RV_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_reg(input string name, input logic [`RV_REG_AW-1:0] expected,
                             input logic [`RV_REG_AW-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected x%0d, got x%0d", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    always @(negedge i_clk) begin : retire_monitor
        retire_t rec;
        neg_count = neg_count + 32'd1;
        if (o_wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Retire at %0t with no instruction outstanding", $time);
                err_count++;
            end else begin
                rec = exp_q.pop_front();
                if (neg_count != rec.cycle) begin
                    $display("Retire at %0t came on cycle %0d instead of cycle %0d",
                             $time, neg_count, rec.cycle);
                    err_count++;
                end
                check_flag("o_wb_illegal", rec.illegal, o_wb_illegal);
                check_flag("o_wb_we", rec.we, o_wb_we);
                if (!rec.illegal) begin
                    check_reg("o_wb_rd", rec.rd, o_wb_rd);
                    check_data("o_wb_data", rec.data, o_wb_data);
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles with %0d retires still missing",
                     cycle_count, exp_q.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic close_test(input string name, input int errs_before);
        @(posedge i_clk);
        i_instr_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge i_clk);
        end
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : main
        logic [31:0]           r;
        logic [`RV_REG_AW-1:0] dst;
        int                    errs;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        for (int k = 0; k < `RV_NUM_REGS; k++) begin
            model_regs[k] = '0;
        end
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // Seed x1..x7 with spread values, then all OP encodings
        errs = err_count;
        for (int k = 1; k < 8; k++) begin
            r = lcg_next();
            issue(encode_i(r[31:20], 5'd0, 3'd0, 5'(k)), 0);
            issue(encode_i({7'h00, r[4:0]}, 5'(k), 3'd1, 5'(k)), 0);
        end
        for (int n = 0; n < 80; n++) begin
            issue(rand_op(rand_reg(), rand_reg(), rand_reg()), 0);
        end
        close_test("reg_reg_ops", errs);

        errs = err_count;
        for (int n = 0; n < 80; n++) begin
            issue(rand_imm(rand_reg(), rand_reg()), 0);
        end
        close_test("imm_ops", errs);

        errs = err_count;
        for (int n = 0; n < 40; n++) begin
            dst = rand_dst();
            r   = lcg_next();
            issue(r[5] ? rand_op(dst, rand_reg(), rand_reg()) : rand_imm(dst, rand_reg()), 0);
            issue(rand_op(rand_reg(), dst, r[6] ? dst : rand_reg()), 0);
        end
        close_test("back_to_back", errs);

        errs = err_count;
        for (int n = 0; n < 30; n++) begin
            dst = rand_dst();
            r   = lcg_next();
            issue(rand_imm(dst, rand_reg()), int'(r[20]));
            issue(rand_op(rand_reg(), rand_reg(), rand_reg()), int'(r[21]));
            issue(rand_op(rand_reg(), rand_reg(), dst), int'(r[22]));
        end
        close_test("two_apart_gaps", errs);

        errs = err_count;
        for (int n = 0; n < 10; n++) begin
            issue(rand_op(5'd0, rand_reg(), rand_reg()), 0);
            issue(rand_imm(rand_dst(), 5'd0), 0);
        end
        close_test("reg_zero", errs);

        errs = err_count;
        for (int n = 0; n < 30; n++) begin
            r = lcg_next();
            case (n % 4)
                0: issue({r[31:7], (r[6:0] == OPC_OP || r[6:0] == OPC_OP_IMM) ?
                                   r[6:0] ^ 7'h04 : r[6:0]}, 0);
                1: issue(encode_r(r[31:25] | 7'h01, rand_reg(), rand_reg(), r[14:12],
                                  rand_dst()), 0);
                2: issue(encode_i({r[31:25] | 7'h02, r[24:20]}, rand_reg(),
                                  r[12] ? 3'd1 : 3'd5, rand_dst()), 0);
                default: issue(rand_op(rand_reg(), rand_reg(), rand_reg()), 0);
            endcase
        end
        close_test("illegal", errs);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if ((tests_failed == 0) && (err_count == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.sv
// ==================================================
// Three-stage RV32I OP/OP-IMM pipeline: ID, EX, WB
// One instruction per strobe, no back-pressure, no stalls
// Each strobe retires on o_wb_valid three edges later
// ==================================================
`default_nettype none

`include "rv_defines.svh"

module rv_core (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_instr_valid,
    input  logic [`RV_XLEN-1:0]   i_instr,
    output logic                  o_wb_valid,
    output logic                  o_wb_we,
    output logic                  o_wb_illegal,
    output logic [`RV_REG_AW-1:0] o_wb_rd,
    output logic [`RV_XLEN-1:0]   o_wb_data
);

    // IF/ID
    logic                  r_ifid_valid;
    rv_pkg::rv_instr_u     r_ifid_instr;

    // Decode and register read
    logic [`RV_REG_AW-1:0] w_id_rs1;
    logic [`RV_REG_AW-1:0] w_id_rs2;
    logic [`RV_REG_AW-1:0] w_id_rd;
    logic [`RV_XLEN-1:0]   w_id_imm;
    rv_pkg::rv_ctrl_t      w_id_ctrl;
    logic [`RV_XLEN-1:0]   w_rf_rs1_data;
    logic [`RV_XLEN-1:0]   w_rf_rs2_data;

    // ID/EX
    logic                  r_idex_valid;
    rv_pkg::rv_ctrl_t      r_idex_ctrl;
    logic [`RV_REG_AW-1:0] r_idex_rs1;
    logic [`RV_REG_AW-1:0] r_idex_rs2;
    logic [`RV_REG_AW-1:0] r_idex_rd;
    logic [`RV_XLEN-1:0]   r_idex_rs1_data;
    logic [`RV_XLEN-1:0]   r_idex_rs2_data;
    logic [`RV_XLEN-1:0]   r_idex_imm;
    logic [`RV_XLEN-1:0]   w_ex_result;

    // EX/WB
    logic                  r_exwb_valid;
    logic                  r_exwb_we;
    logic                  r_exwb_illegal;
    logic [`RV_REG_AW-1:0] r_exwb_rd;
    logic [`RV_XLEN-1:0]   r_exwb_data;

    // ==================================================
    // Decode stage
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_ifid_valid <= 1'b0;
        end else begin
            r_ifid_valid <= i_instr_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            r_ifid_instr <= i_instr;
        end
    end

    rv_decode u_decode (
        .i_instr (r_ifid_instr),
        .o_rs1   (w_id_rs1),
        .o_rs2   (w_id_rs2),
        .o_rd    (w_id_rd),
        .o_imm   (w_id_imm),
        .o_ctrl  (w_id_ctrl)
    );

    // Reads in ID, writes from WB
    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (w_id_rs1),
        .i_rs2_addr (w_id_rs2),
        .o_rs1_data (w_rf_rs1_data),
        .o_rs2_data (w_rf_rs2_data),
        .i_wr_en    (r_exwb_we),
        .i_rd_addr  (r_exwb_rd),
        .i_rd_data  (r_exwb_data)
    );

    // ==================================================
    // Execute stage
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_idex_valid <= 1'b0;
            r_idex_ctrl  <= '0;
        end else begin
            r_idex_valid <= r_ifid_valid;
            r_idex_ctrl  <= w_id_ctrl;
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_ifid_valid) begin
            r_idex_rs1      <= w_id_rs1;
            r_idex_rs2      <= w_id_rs2;
            r_idex_rd       <= w_id_rd;
            r_idex_rs1_data <= w_rf_rs1_data;
            r_idex_rs2_data <= w_rf_rs2_data;
            r_idex_imm      <= w_id_imm;
        end
    end

    rv_execute u_execute (
        .i_rs1_addr (r_idex_rs1),
        .i_rs2_addr (r_idex_rs2),
        .i_rs1_data (r_idex_rs1_data),
        .i_rs2_data (r_idex_rs2_data),
        .i_imm      (r_idex_imm),
        .i_ctrl     (r_idex_ctrl),
        .i_fwd_we   (r_exwb_we),
        .i_fwd_rd   (r_exwb_rd),
        .i_fwd_data (r_exwb_data),
        .o_result   (w_ex_result)
    );

    // ==================================================
    // Writeback stage
    // ==================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_exwb_valid   <= 1'b0;
            r_exwb_we      <= 1'b0;
            r_exwb_illegal <= 1'b0;
        end else begin
            // Bubbles carry stale control, so qualify with valid
            r_exwb_valid   <= r_idex_valid;
            r_exwb_we      <= r_idex_valid && r_idex_ctrl.reg_write;
            r_exwb_illegal <= r_idex_valid && r_idex_ctrl.illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_idex_valid) begin
            r_exwb_rd   <= r_idex_rd;
            r_exwb_data <= w_ex_result;
        end
    end

    assign o_wb_valid   = r_exwb_valid;
    assign o_wb_we      = r_exwb_we;
    assign o_wb_illegal = r_exwb_illegal;
    assign o_wb_rd      = r_exwb_rd;
    assign o_wb_data    = r_exwb_data;

    // A register write is always part of a retire
    a_we_with_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_we |-> o_wb_valid);

endmodule

`default_nettype wire

// File: rv_execute.sv
// ==================================================
// Operand forwarding from EX/WB and the integer ALU
// Shifts use only the low five bits of operand B
// ==================================================
`default_nettype none

`include "rv_defines.svh"

module rv_execute (
    input  logic [`RV_REG_AW-1:0] i_rs1_addr,
    input  logic [`RV_REG_AW-1:0] i_rs2_addr,
    input  logic [`RV_XLEN-1:0]   i_rs1_data,
    input  logic [`RV_XLEN-1:0]   i_rs2_data,
    input  logic [`RV_XLEN-1:0]   i_imm,
    input  rv_pkg::rv_ctrl_t      i_ctrl,
    input  logic                  i_fwd_we,
    input  logic [`RV_REG_AW-1:0] i_fwd_rd,
    input  logic [`RV_XLEN-1:0]   i_fwd_data,
    output logic [`RV_XLEN-1:0]   o_result
);

    logic [`RV_XLEN-1:0]    op_a;
    logic [`RV_XLEN-1:0]    rs2_val;
    logic [`RV_XLEN-1:0]    op_b;
    logic [`RV_SHAMT_W-1:0] shamt;

    // EX/WB never writes x0, so no zero check here
    function automatic logic [`RV_XLEN-1:0] pick_operand(
        input logic [`RV_REG_AW-1:0] src,
        input logic [`RV_XLEN-1:0]   rf_data,
        input logic                  fwd_we,
        input logic [`RV_REG_AW-1:0] fwd_rd,
        input logic [`RV_XLEN-1:0]   fwd_data
    );
        return (fwd_we && (fwd_rd == src)) ? fwd_data : rf_data;
    endfunction

    assign op_a    = pick_operand(i_rs1_addr, i_rs1_data, i_fwd_we, i_fwd_rd, i_fwd_data);
    assign rs2_val = pick_operand(i_rs2_addr, i_rs2_data, i_fwd_we, i_fwd_rd, i_fwd_data);
    assign op_b    = i_ctrl.use_imm ? i_imm : rs2_val;
    assign shamt   = op_b[`RV_SHAMT_W-1:0];

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (i_ctrl.alu_op)
            rv_pkg::ALU_ADD:  o_result = op_a + op_b;
            rv_pkg::ALU_SUB:  o_result = op_a - op_b;
            rv_pkg::ALU_SLL:  o_result = op_a << shamt;
            rv_pkg::ALU_SLT:  o_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: o_result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:  o_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:  o_result = op_a >> shamt;
            rv_pkg::ALU_SRA:  o_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   o_result = op_a | op_b;
            default:          o_result = op_a & op_b;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_regfile.sv
// ==================================================
// 32 x XLEN register file, two read ports, one write port
// x0 reads zero; a same-cycle write is bypassed to the reads
// ==================================================
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [`RV_REG_AW-1:0] i_rs1_addr,
    input  logic [`RV_REG_AW-1:0] i_rs2_addr,
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data,
    input  logic                  i_wr_en,
    input  logic [`RV_REG_AW-1:0] i_rd_addr,
    input  logic [`RV_XLEN-1:0]   i_rd_data
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];
    logic                wr_live;

    assign wr_live = i_wr_en && (i_rd_addr != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 1; k < `RV_NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_live) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_live && (addr == i_rd_addr)) begin
            // Write-through for the instruction two ahead
            return i_rd_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

    // x0 stays zero even while WB targets it
    a_rs1_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rs1_addr == '0) |-> (o_rs1_data == '0));
    a_rs2_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rs2_addr == '0) |-> (o_rs2_data == '0));

endmodule

`default_nettype wire

// File: rv_decode.sv
// ==================================================
// Combinational decoder for OP and OP-IMM instructions
// Unknown opcodes and bad funct7 values are flagged illegal
// ==================================================
`default_nettype none

`include "rv_defines.svh"

module rv_decode (
    input  rv_pkg::rv_instr_u     i_instr,
    output logic [`RV_REG_AW-1:0] o_rs1,
    output logic [`RV_REG_AW-1:0] o_rs2,
    output logic [`RV_REG_AW-1:0] o_rd,
    output logic [`RV_XLEN-1:0]   o_imm,
    output rv_pkg::rv_ctrl_t      o_ctrl
);

    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;

    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               alt;
    logic               use_imm;
    logic               illegal;
    rv_pkg::rv_alu_op_e alu_op;

    // Register fields sit at the same place in both formats
    assign o_rs1 = i_instr.r.rs1;
    assign o_rs2 = i_instr.r.rs2;
    assign o_rd  = i_instr.r.rd;
    assign o_imm = {{(`RV_XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};

    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;
    assign alt    = (funct7 == F7_ALT);

    always_comb begin
        alu_op  = rv_pkg::ALU_ADD;
        use_imm = 1'b0;
        illegal = 1'b0;
        case (i_instr.r.opcode)
            rv_pkg::OPC_OP: begin
                // Alternate funct7 only exists for SUB and SRA
                illegal = !((funct7 == F7_BASE) ||
                            (alt && ((funct3 == 3'b000) || (funct3 == 3'b101))));
                case (funct3)
                    3'b000:  alu_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  alu_op = rv_pkg::ALU_SLL;
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    3'b011:  alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  alu_op = rv_pkg::ALU_XOR;
                    3'b101:  alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    default: alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    3'b000:  alu_op = rv_pkg::ALU_ADD;
                    3'b001: begin
                        alu_op  = rv_pkg::ALU_SLL;
                        illegal = (funct7 != F7_BASE);
                    end
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    3'b011:  alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  alu_op = rv_pkg::ALU_XOR;
                    3'b101: begin
                        // SRAI vs SRLI, upper immediate bits act as funct7
                        alu_op  = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        illegal = !((funct7 == F7_BASE) || alt);
                    end
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    default: alu_op = rv_pkg::ALU_AND;
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

    assign o_ctrl = '{
        alu_op:    alu_op,
        use_imm:   use_imm,
        reg_write: !illegal && (o_rd != '0),
        illegal:   illegal
    };

endmodule

`default_nettype wire

// File: rv_pkg.sv
// ==================================================
// Shared types for the OP / OP-IMM subset of RV32I
// Any opcode other than OP and OP-IMM is decoded as illegal
// ==================================================
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    // ==================================================
    // Encodings
    // ==================================================

    // Only the two supported major opcodes get names
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } rv_alu_op_e;

    // ==================================================
    // Instruction word
    // ==================================================

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        rv_opcode_e            opcode;
    } rv_r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        rv_opcode_e            opcode;
    } rv_i_type_t;

    // Same 32 bits seen as R-type or as I-type
    typedef union packed {
        rv_r_type_t r;
        rv_i_type_t i;
    } rv_instr_u;

    // Decoded control carried down the pipeline
    typedef struct packed {
        rv_alu_op_e alu_op;
        logic       use_imm;
        logic       reg_write;
        logic       illegal;
    } rv_ctrl_t;

endpackage

`default_nettype wire

// File: rv_defines.svh
// ==================================================
// Width and count macros for the RV32I subset core
// Only XLEN of 32 and a 32-entry register file are supported
// ==================================================
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path width
`define RV_XLEN 32

// Register file geometry
`define RV_REG_AW   5
`define RV_NUM_REGS 32

// Shift amount, taken from the low bits of operand B
`define RV_SHAMT_W 5

`endif
